//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps -j 0
TOP       ?= tb_uart_manage
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := Everything OK

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- flist.f
rtl/uart_pkg.sv
rtl/uart_rx.sv
rtl/uart_tx.sv
rtl/byte_ring.sv
rtl/uart_word_access.sv
rtl/uart_manage.sv
tb/tb_serial_model.sv
tb/tb_uart_manage.sv

//--- rtl/byte_ring.sv
`default_nettype none

module byte_ring
    import uart_pkg::*;
(
    input  wire byte_xfer_t i_push,
    input  wire             i_credit,
    output byte_xfer_t      o_byte,
    output logic            o_credit_return,
    output logic            o_overflow,
    input  wire             clk,
    input  wire             i_rst_n
);

    logic [7:0]          mem [RING_DEPTH];
    logic [RING_ADDR_W:0] wr_ptr;
    logic [RING_ADDR_W:0] rd_ptr;
    logic [CREDIT_W-1:0] credits;
    logic                empty;
    logic                full;
    logic                push_ok;
    logic                send_now;
    logic                out_valid;
    logic [7:0]          out_data;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[RING_ADDR_W] != rd_ptr[RING_ADDR_W]) &&
                   (wr_ptr[RING_ADDR_W-1:0] == rd_ptr[RING_ADDR_W-1:0]);

    assign push_ok = i_push.valid && !full;

    // a fresh credit may be served in the same cycle it arrives
    assign send_now = ((credits != '0) || i_credit) && !empty;

    assign o_byte          = '{valid: out_valid, data: out_data};
    assign o_credit_return = out_valid;

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            credits    <= '0;
            out_valid  <= 1'b0;
            o_overflow <= 1'b0;
        end else begin
            credits    <= credits + CREDIT_W'(i_credit) - CREDIT_W'(send_now);
            out_valid  <= send_now;
            o_overflow <= i_push.valid && full;
            if (push_ok) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (send_now) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push_ok) begin
            mem[wr_ptr[RING_ADDR_W-1:0]] <= i_push.data;
        end
        if (send_now) begin
            out_data <= mem[rd_ptr[RING_ADDR_W-1:0]];
        end
    end

    // occupancy wraps past depth if reads ever outrun writes
    a_no_underflow: assert property (@(posedge clk) disable iff (!i_rst_n)
        CREDIT_W'(wr_ptr - rd_ptr) <= CREDIT_W'(RING_DEPTH));

endmodule

`default_nettype wire

//--- rtl/uart_manage.sv
`default_nettype none

module uart_manage
    import uart_pkg::*;
(
    input  wire            i_order,
    input  wire word_req_t i_req,
    output logic           o_accepted,
    output logic           o_done,
    output logic [31:0]    o_read_data,

    input  wire            i_rxd,
    output logic           o_txd,
    output logic           o_rx_overflow,

    input  wire            clk,
    input  wire            i_rst_n
);

    byte_xfer_t rx_frame;
    byte_xfer_t rx_byte;
    logic       rx_credit;

    byte_xfer_t tx_push;
    byte_xfer_t tx_byte;
    logic       tx_credit_return;
    logic       tx_pop;

    // receive path
    uart_rx u_rx (
        .i_rxd   (i_rxd),
        .o_byte  (rx_frame),
        .clk     (clk),
        .i_rst_n (i_rst_n)
    );

    byte_ring u_rx_ring (
        .i_push          (rx_frame),
        .i_credit        (rx_credit),
        .o_byte          (rx_byte),
        .o_credit_return (),
        .o_overflow      (o_rx_overflow),
        .clk             (clk),
        .i_rst_n         (i_rst_n)
    );

    uart_word_access u_access (
        .i_order            (i_order),
        .i_req              (i_req),
        .o_accepted         (o_accepted),
        .o_done             (o_done),
        .o_read_data        (o_read_data),
        .o_rx_credit        (rx_credit),
        .i_rx_byte          (rx_byte),
        .o_tx_byte          (tx_push),
        .i_tx_credit_return (tx_credit_return),
        .clk                (clk),
        .i_rst_n            (i_rst_n)
    );

    // transmit path, pops act as ring credits
    byte_ring u_tx_ring (
        .i_push          (tx_push),
        .i_credit        (tx_pop),
        .o_byte          (tx_byte),
        .o_credit_return (tx_credit_return),
        .o_overflow      (),
        .clk             (clk),
        .i_rst_n         (i_rst_n)
    );

    uart_tx u_tx (
        .i_byte  (tx_byte),
        .o_pop   (tx_pop),
        .o_txd   (o_txd),
        .clk     (clk),
        .i_rst_n (i_rst_n)
    );

endmodule

`default_nettype wire

//--- rtl/uart_pkg.sv
`default_nettype none

package uart_pkg;

    // line timing
    localparam int CLK_PER_BIT = 16;
    localparam int BIT_CNT_W   = $clog2(CLK_PER_BIT);

    // ring buffers, also the initial credit
    localparam int RING_ADDR_W = 3;
    localparam int RING_DEPTH  = 1 << RING_ADDR_W;
    localparam int CREDIT_W    = RING_ADDR_W + 1;

    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } size_e;

    typedef struct packed {
        size_e       size;
        logic        write;
        logic [31:0] data;
    } word_req_t;

    typedef struct packed {
        logic       valid;
        logic [7:0] data;
    } byte_xfer_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WRITE,
        ST_READ
    } access_state_e;

    // shared by both serial directions
    typedef enum logic [1:0] {
        LN_IDLE,
        LN_START,
        LN_DATA,
        LN_STOP
    } line_state_e;

endpackage

`default_nettype wire

//--- rtl/uart_rx.sv
`default_nettype none

module uart_rx
    import uart_pkg::*;
(
    input  wire        i_rxd,
    output byte_xfer_t o_byte,
    input  wire        clk,
    input  wire        i_rst_n
);

    logic [1:0]           sync_q;
    logic                 rxd_s;
    line_state_e          state;
    logic [BIT_CNT_W-1:0] cnt;
    logic [2:0]           bit_idx;
    logic [7:0]           shreg;
    logic                 out_valid;
    logic                 half_bit;
    logic                 bit_end;

    assign rxd_s    = sync_q[1];
    assign half_bit = (cnt == BIT_CNT_W'(CLK_PER_BIT / 2 - 1));
    assign bit_end  = (cnt == BIT_CNT_W'(CLK_PER_BIT - 1));

    assign o_byte = '{valid: out_valid, data: shreg};

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            sync_q    <= 2'b11;
            state     <= LN_IDLE;
            cnt       <= '0;
            bit_idx   <= '0;
            out_valid <= 1'b0;
        end else begin
            sync_q    <= {sync_q[0], i_rxd};
            out_valid <= 1'b0;
            case (state)
                LN_IDLE: begin
                    if (!rxd_s) begin
                        state <= LN_START;
                        cnt   <= '0;
                    end
                end
                LN_START: begin
                    // recheck the start bit at its middle
                    if (half_bit) begin
                        cnt     <= '0;
                        bit_idx <= '0;
                        state   <= rxd_s ? LN_IDLE : LN_DATA;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                LN_DATA: begin
                    if (bit_end) begin
                        cnt     <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= LN_STOP;
                        end
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: begin
                    // low stop bit drops the frame
                    if (bit_end) begin
                        state     <= LN_IDLE;
                        out_valid <= rxd_s;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    // lsb arrives first
    always_ff @(posedge clk) begin
        if (state == LN_DATA && bit_end) begin
            shreg <= {rxd_s, shreg[7:1]};
        end
    end

    a_single_pulse: assert property (@(posedge clk) disable iff (!i_rst_n)
        o_byte.valid |=> !o_byte.valid);

endmodule

`default_nettype wire

//--- rtl/uart_tx.sv
`default_nettype none

module uart_tx
    import uart_pkg::*;
(
    input  wire byte_xfer_t i_byte,
    output logic            o_pop,
    output logic            o_txd,
    input  wire             clk,
    input  wire             i_rst_n
);

    line_state_e          state;
    logic                 pending;
    logic [BIT_CNT_W-1:0] cnt;
    logic [2:0]           bit_idx;
    logic [7:0]           shreg;
    logic                 bit_end;

    assign bit_end = (cnt == BIT_CNT_W'(CLK_PER_BIT - 1));

    // one pop outstanding at a time
    assign o_pop = (state == LN_IDLE) && !pending;

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state   <= LN_IDLE;
            pending <= 1'b0;
            cnt     <= '0;
            bit_idx <= '0;
            o_txd   <= 1'b1;
        end else begin
            case (state)
                LN_IDLE: begin
                    if (o_pop) begin
                        pending <= 1'b1;
                    end
                    if (i_byte.valid) begin
                        pending <= 1'b0;
                        state   <= LN_START;
                        cnt     <= '0;
                        o_txd   <= 1'b0;
                    end
                end
                LN_START: begin
                    if (bit_end) begin
                        cnt     <= '0;
                        bit_idx <= '0;
                        state   <= LN_DATA;
                        o_txd   <= shreg[0];
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                LN_DATA: begin
                    if (bit_end) begin
                        cnt     <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= LN_STOP;
                            o_txd <= 1'b1;
                        end else begin
                            o_txd <= shreg[1];
                        end
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: begin
                    if (bit_end) begin
                        cnt   <= '0;
                        state <= LN_IDLE;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == LN_IDLE && i_byte.valid) begin
            shreg <= i_byte.data;
        end else if (state == LN_DATA && bit_end) begin
            shreg <= {1'b0, shreg[7:1]};
        end
    end

    a_idle_high: assert property (@(posedge clk) disable iff (!i_rst_n)
        state == LN_IDLE |-> o_txd);

endmodule

`default_nettype wire

//--- rtl/uart_word_access.sv
`default_nettype none

module uart_word_access
    import uart_pkg::*;
(
    input  wire             i_order,
    input  wire word_req_t  i_req,
    output logic            o_accepted,
    output logic            o_done,
    output logic [31:0]     o_read_data,

    output logic            o_rx_credit,
    input  wire byte_xfer_t i_rx_byte,

    output byte_xfer_t      o_tx_byte,
    input  wire             i_tx_credit_return,

    input  wire             clk,
    input  wire             i_rst_n
);

    access_state_e       state;
    size_e               size_q;
    logic [2:0]          count;
    logic [2:0]          rx_owed;
    logic [CREDIT_W-1:0] tx_credit;
    logic [31:0]         shreg;
    logic [31:0]         read_q;

    logic                tx_send;
    logic                rd_take;
    logic                wr_last;
    logic                rd_last;
    logic [2:0]          req_count;
    logic [31:0]         req_aligned;
    logic [31:0]         rd_joined;
    logic [31:0]         rd_ext;

    assign o_accepted = (state == ST_IDLE) && i_order;

    assign tx_send = (state == ST_WRITE) && (tx_credit != '0);
    assign rd_take = (state == ST_READ) && i_rx_byte.valid;
    assign wr_last = tx_send && (count == 3'd1);
    assign rd_last = rd_take && (count == 3'd1);
    assign o_done  = wr_last || rd_last;

    // msb leaves first
    assign o_tx_byte = '{valid: tx_send, data: shreg[31:24]};

    // never ask for more than is still missing
    assign o_rx_credit = (state == ST_READ) && (rx_owed < count);

    assign rd_joined   = {shreg[23:0], i_rx_byte.data};
    assign o_read_data = rd_last ? rd_ext : read_q;

    always_comb begin
        case (i_req.size)
            SIZE_BYTE: begin
                req_count   = 3'd1;
                req_aligned = {i_req.data[7:0], 24'h0};
            end
            SIZE_HALF: begin
                req_count   = 3'd2;
                req_aligned = {i_req.data[15:0], 16'h0};
            end
            default: begin
                req_count   = 3'd4;
                req_aligned = i_req.data;
            end
        endcase
    end

    // sign extension by captured size
    always_comb begin
        case (size_q)
            SIZE_BYTE: rd_ext = {{24{rd_joined[7]}}, rd_joined[7:0]};
            SIZE_HALF: rd_ext = {{16{rd_joined[15]}}, rd_joined[15:0]};
            default:   rd_ext = rd_joined;
        endcase
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state     <= ST_IDLE;
            size_q    <= SIZE_BYTE;
            count     <= '0;
            rx_owed   <= '0;
            tx_credit <= CREDIT_W'(RING_DEPTH);
            read_q    <= '0;
        end else begin
            tx_credit <= tx_credit - CREDIT_W'(tx_send) + CREDIT_W'(i_tx_credit_return);
            rx_owed   <= rx_owed + 3'(o_rx_credit) - 3'(rd_take);
            case (state)
                ST_IDLE: begin
                    if (o_accepted) begin
                        size_q <= i_req.size;
                        count  <= req_count;
                        state  <= i_req.write ? ST_WRITE : ST_READ;
                    end
                end
                ST_WRITE: begin
                    if (tx_send) begin
                        count <= count - 1'b1;
                    end
                    if (wr_last) begin
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    if (rd_take) begin
                        count <= count - 1'b1;
                    end
                    if (rd_last) begin
                        state  <= ST_IDLE;
                        read_q <= rd_ext;
                    end
                end
            endcase
        end
    end

    // one shifter serves both directions
    always_ff @(posedge clk) begin
        if (o_accepted) begin
            shreg <= req_aligned;
        end else if (tx_send) begin
            shreg <= {shreg[23:0], 8'h00};
        end else if (rd_take) begin
            shreg <= rd_joined;
        end
    end

    a_tx_credit_max: assert property (@(posedge clk) disable iff (!i_rst_n)
        tx_credit <= CREDIT_W'(RING_DEPTH));

    a_accept_idle: assert property (@(posedge clk) disable iff (!i_rst_n)
        o_accepted |-> (state == ST_IDLE) ##1 (state != ST_IDLE));

endmodule

`default_nettype wire

//--- tb/tb_serial_model.sv
`default_nettype none

// drives queued bytes onto the receive line as 8N1 frames
module tb_line_driver
    import uart_pkg::*;
(
    input  wire        clk,
    input  wire        i_push,
    input  wire  [7:0] i_push_data,
    output logic       o_rxd,
    output int         o_frames_sent
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [7:0] pending [$];

    always @(posedge clk) begin
        if (i_push) begin
            pending.push_back(i_push_data);
        end
    end

    initial begin
        logic [9:0] frame;
        o_rxd         = 1'b1;
        o_frames_sent = 0;
        forever begin
            @(negedge clk);
            if (pending.size() != 0) begin
                // start bit goes out first, stop bit last
                frame = {1'b1, pending.pop_front(), 1'b0};
                for (int i = 0; i < 10; i++) begin
                    @(posedge clk);
                    #1 o_rxd = frame[i];
                    repeat (CLK_PER_BIT - 1) @(posedge clk);
                end
                o_frames_sent++;
            end
        end
    end

endmodule

// decodes frames seen on the transmit line
module tb_line_monitor
    import uart_pkg::*;
(
    input  wire        clk,
    input  wire        i_txd,
    output logic       o_valid,
    output logic [7:0] o_data,
    output logic       o_stop_err
);
    timeunit 1ns;
    timeprecision 100ps;

    // line moves on rising edges, sampled on falling ones
    initial begin
        logic [7:0] data;
        o_valid    = 1'b0;
        o_data     = '0;
        o_stop_err = 1'b0;
        forever begin
            @(negedge clk);
            #1 o_valid = 1'b0;
            if (i_txd === 1'b0) begin
                repeat (CLK_PER_BIT / 2) @(negedge clk);
                for (int i = 0; i < 8; i++) begin
                    repeat (CLK_PER_BIT) @(negedge clk);
                    data[i] = i_txd;
                end
                repeat (CLK_PER_BIT) @(negedge clk);
                #1;
                o_stop_err = (i_txd !== 1'b1);
                o_data     = data;
                o_valid    = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- tb/tb_uart_manage.sv
`default_nettype none

module tb_uart_manage
    import uart_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int SEED      = 40736;
    // write burst stops after at most RING_DEPTH + 7 bytes
    localparam int TX_FRAMES = 7 + RING_DEPTH + 7;
    localparam int RX_FRAMES = 14 + 9 + RING_DEPTH + 3;
    // frames run one after another in the worst case, plus gaps
    localparam int TIMEOUT_CYCLES = (TX_FRAMES + RX_FRAMES) * 12 * CLK_PER_BIT + 2000;

    logic        clk;
    logic        i_rst_n;
    logic        i_order;
    word_req_t   i_req;
    logic        o_accepted;
    logic        o_done;
    logic [31:0] o_read_data;
    logic        rxd;
    logic        o_txd;
    logic        o_rx_overflow;

    logic        line_push;
    logic [7:0]  line_data;
    int          frames_sent;
    logic        mon_valid;
    logic [7:0]  mon_data;
    logic        mon_stop_err;

    int errors           = 0;
    int checks           = 0;
    int done_count       = 0;
    int write_done_count = 0;
    int overflow_count   = 0;
    int orders_issued    = 0;
    int writes_issued    = 0;
    int frames_queued    = 0;
    int cycle_count      = 0;

    logic [7:0]  exp_tx [$];
    logic [31:0] exp_reads [$];
    logic        order_kinds [$];
    logic [7:0]  rx_model [$];

    uart_manage DUT (
        .i_order       (i_order),
        .i_req         (i_req),
        .o_accepted    (o_accepted),
        .o_done        (o_done),
        .o_read_data   (o_read_data),
        .i_rxd         (rxd),
        .o_txd         (o_txd),
        .o_rx_overflow (o_rx_overflow),
        .clk           (clk),
        .i_rst_n       (i_rst_n)
    );

    tb_line_driver u_line_driver (
        .clk           (clk),
        .i_push        (line_push),
        .i_push_data   (line_data),
        .o_rxd         (rxd),
        .o_frames_sent (frames_sent)
    );

    tb_line_monitor u_line_monitor (
        .clk        (clk),
        .i_txd      (o_txd),
        .o_valid    (mon_valid),
        .o_data     (mon_data),
        .o_stop_err (mon_stop_err)
    );

    function automatic int size_bytes(input size_e size);
        case (size)
            SIZE_BYTE: return 1;
            SIZE_HALF: return 2;
            default:   return 4;
        endcase
    endfunction

    // bytes[0] arrived first and carries the sign
    function automatic logic [31:0] ref_read_value(input size_e size,
                                                   input logic [3:0][7:0] bytes);
        int          n;
        logic [31:0] acc;
        n   = size_bytes(size);
        acc = '0;
        for (int i = 0; i < n; i++) begin
            acc = (acc << 8) | 32'(bytes[i]);
        end
        if (n < 4 && bytes[0][7]) begin
            acc = acc | (32'hFFFF_FFFF << (8 * n));
        end
        return acc;
    endfunction

    // low n bytes of data, top one first on the line
    function automatic void ref_write_bytes(input size_e size, input logic [31:0] data,
                                            output int n, output logic [3:0][7:0] bytes);
        n     = size_bytes(size);
        bytes = '0;
        for (int i = 0; i < n; i++) begin
            bytes[i] = 8'(data >> (8 * (n - 1 - i)));
        end
    endfunction

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        checks++;
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t: %s, got %h, expected %h",
                     $time, what, actual, expected);
            errors++;
        end
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic wait_all_done();
        while (done_count < orders_issued) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic wait_frames_sent(input int n);
        while (frames_sent < n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic wait_tx_drain();
        while (exp_tx.size() != 0) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic issue_order(input logic write, input size_e size, input logic [31:0] data);
        logic acc;
        acc     = 1'b0;
        i_order = 1'b1;
        i_req   = '{size: size, write: write, data: data};
        while (!acc) begin
            @(negedge clk);
            acc = o_accepted;
            @(posedge clk);
            #1;
        end
        i_order = 1'b0;
    endtask

    task automatic do_write(input size_e size, input logic [31:0] data);
        logic [3:0][7:0] bytes;
        int              n;
        ref_write_bytes(size, data, n, bytes);
        for (int i = 0; i < n; i++) begin
            exp_tx.push_back(bytes[i]);
        end
        order_kinds.push_back(1'b1);
        orders_issued++;
        writes_issued++;
        issue_order(1'b1, size, data);
    endtask

    task automatic do_read(input size_e size);
        logic [3:0][7:0] bytes;
        int              n;
        n     = size_bytes(size);
        bytes = '0;
        for (int i = 0; i < n; i++) begin
            if (rx_model.size() == 0) begin
                $display("error at %0t: read ordered before its bytes were queued", $time);
                errors++;
            end else begin
                bytes[i] = rx_model.pop_front();
            end
        end
        exp_reads.push_back(ref_read_value(size, bytes));
        order_kinds.push_back(1'b0);
        orders_issued++;
        issue_order(1'b0, size, 32'h0);
    endtask

    task automatic send_frame(input logic [7:0] data, input logic kept);
        line_push = 1'b1;
        line_data = data;
        @(posedge clk);
        #1 line_push = 1'b0;
        frames_queued++;
        if (kept) begin
            rx_model.push_back(data);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, the run did not finish", cycle_count);
            $display("Something failed");
            $finish;
        end
    end

    // compare process for completed orders and transmitted bytes
    always @(negedge clk) begin
        logic kind;
        if (i_rst_n) begin
            if (o_done) begin
                done_count++;
                if (order_kinds.size() == 0) begin
                    $display("error at %0t: o_done pulsed with no order outstanding", $time);
                    errors++;
                end else begin
                    kind = order_kinds.pop_front();
                    if (kind) begin
                        write_done_count++;
                    end else begin
                        check_value(o_read_data, exp_reads.pop_front(), "read data");
                    end
                end
            end
            if (mon_valid) begin
                if (mon_stop_err) begin
                    $display("error at %0t: transmitted frame has a low stop bit", $time);
                    errors++;
                end
                if (exp_tx.size() == 0) begin
                    $display("error at %0t: unexpected frame %h on o_txd", $time, mon_data);
                    errors++;
                end else begin
                    check_value(32'(mon_data), 32'(exp_tx.pop_front()), "transmitted byte");
                end
            end
            if (o_rx_overflow) begin
                overflow_count++;
            end
        end
    end

    initial begin
        size_e       size;
        logic [7:0]  b;
        int          total;
        int          base;

        void'($urandom(SEED));
        i_rst_n   = 1'b0;
        i_order   = 1'b0;
        i_req     = '0;
        line_push = 1'b0;
        line_data = '0;
        repeat (5) @(posedge clk);
        #1 i_rst_n = 1'b1;

        // idle state after reset
        @(negedge clk);
        check_value(32'(o_txd), 32'd1, "o_txd after reset");
        check_value(32'(o_done), 32'd0, "o_done after reset");
        check_value(32'(o_rx_overflow), 32'd0, "o_rx_overflow after reset");
        check_value(32'(o_accepted), 32'd0, "o_accepted without order");
        check_value(o_read_data, 32'd0, "o_read_data after reset");
        @(posedge clk);
        #1;

        // one write of each size
        do_write(SIZE_BYTE, $urandom);
        do_write(SIZE_HALF, $urandom);
        do_write(SIZE_WORD, $urandom);
        wait_all_done();
        wait_tx_drain();

        // reads of each size, both sign values
        for (int s = 0; s < 3; s++) begin
            for (int sign = 1; sign >= 0; sign--) begin
                size = size_e'(s);
                for (int i = 0; i < size_bytes(size); i++) begin
                    b = 8'($urandom);
                    if (i == 0) begin
                        b[7] = sign[0];
                    end
                    send_frame(b, 1'b1);
                end
                do_read(size);
                wait_all_done();
            end
        end

        // read waits for its last frame
        for (int i = 0; i < 4; i++) begin
            send_frame(8'($urandom), 1'b1);
        end
        do_read(SIZE_WORD);
        wait_frames_sent(frames_queued - 1);
        wait_cycles(CLK_PER_BIT);
        check_value(32'(done_count), 32'(orders_issued - 1), "read done before last byte");
        wait_all_done();

        // bytes already buffered, consumed in arrival order
        for (int i = 0; i < 5; i++) begin
            send_frame(8'($urandom), 1'b1);
        end
        wait_frames_sent(frames_queued);
        wait_cycles(CLK_PER_BIT);
        do_read(SIZE_BYTE);
        do_read(SIZE_HALF);
        do_read(SIZE_HALF);
        wait_all_done();

        // write burst beyond the transmit credit
        total = 0;
        while (total <= RING_DEPTH + 3) begin
            size = size_e'($urandom_range(0, 2));
            do_write(size, $urandom);
            total += size_bytes(size);
        end
        wait_all_done();
        check_value(32'(write_done_count), 32'(writes_issued), "write done count");
        wait_tx_drain();

        // receive overflow with no read pending
        base = overflow_count;
        for (int i = 0; i < RING_DEPTH + 3; i++) begin
            send_frame(8'($urandom), i < RING_DEPTH);
        end
        wait_frames_sent(frames_queued);
        wait_cycles(CLK_PER_BIT);
        check_value(32'(overflow_count - base), 32'd3, "overflow pulses");
        do_read(SIZE_WORD);
        do_read(SIZE_WORD);
        wait_all_done();

        // room for a stray frame to show up
        wait_tx_drain();
        wait_cycles(11 * CLK_PER_BIT);
        check_value(32'(order_kinds.size()), 32'd0, "orders without o_done");
        check_value(32'(overflow_count), 32'd3, "total overflow pulses");

        $display("summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
